/* design/sw_params.svh */
// score and nucleotide width macros
`ifndef SW_PARAMS_SVH
`define SW_PARAMS_SVH

// ====================
// datapath widths
// ====================

`define SW_SCORE_W 12 // biased score word
`define SW_BASE_W 2 // one nucleotide code

`endif

/* design/sw_score_pkg.sv */
// score and base types, biased zero, unsigned max helper
`include "sw_params.svh"

package sw_score_pkg;

	// ====================
	// types
	// ====================

	typedef logic [`SW_SCORE_W-1:0] score_t; // biased by half the range

	typedef enum logic [`SW_BASE_W-1:0]
	{
		A = 2'd0,
		G = 2'd1,
		T = 2'd2,
		C = 2'd3
	} base_t;

	// biased zero, only msb set
	parameter score_t ZERO = {1'b1, {(`SW_SCORE_W-1){1'b0}}};

	// unsigned compare works directly on biased scores
	function automatic score_t max2(input score_t a, input score_t b);
		return (a > b) ? a : b;
	endfunction

endpackage

/* design/sw_ctrl_pkg.sv */
// run state type for the per-stage controller registers

package sw_ctrl_pkg;

	// ====================
	// stage run state
	// ====================

	typedef enum logic
	{
		IDLE = 1'b0, // waiting for a run
		CALC = 1'b1 // inside a run
	} run_state_t;

endpackage

/* design/sw_pe_ctrl.sv */
// enable pipeline, per-stage run states, first-item flags and end-of-run pulse
`timescale 1ns/10ps

module sw_pe_ctrl
(
	input  logic clk,
	input  logic rst,
	input  logic en_in, // level, high for each base of a run
	output logic s1_load, // stage 1 capture
	output logic s1_first, // first item entering stage 1
	output logic s2_load, // stage 2 capture
	output logic s2_first, // first item entering stage 2
	output logic en_out, // enable to right neighbour, also high stage capture
	output logic hs_first, // first item entering high stage
	output logic high_valid // run finished, high_out final
);

	sw_ctrl_pkg::run_state_t st1; // gap prep stage
	sw_ctrl_pkg::run_state_t st2; // cell score stage
	sw_ctrl_pkg::run_state_t st_hs; // high score stage

	// first flags fire on the item that leaves IDLE
	assign s1_load = en_in;
	assign s1_first = en_in && (st1 == sw_ctrl_pkg::IDLE);
	assign s2_first = s2_load && (st2 == sw_ctrl_pkg::IDLE);
	assign hs_first = en_out && (st_hs == sw_ctrl_pkg::IDLE);

	// ====================
	// enable pipe and states
	// ====================

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			s2_load <= 1'b0;
			en_out <= 1'b0;
			high_valid <= 1'b0;
			st1 <= sw_ctrl_pkg::IDLE;
			st2 <= sw_ctrl_pkg::IDLE;
			st_hs <= sw_ctrl_pkg::IDLE;
		end
		else
		begin
			s2_load <= en_in; // one stage behind
			en_out <= s2_load; // two stages behind
			st1 <= en_in ? sw_ctrl_pkg::CALC : sw_ctrl_pkg::IDLE;
			st2 <= s2_load ? sw_ctrl_pkg::CALC : sw_ctrl_pkg::IDLE;
			st_hs <= en_out ? sw_ctrl_pkg::CALC : sw_ctrl_pkg::IDLE;
			// high stage drops from CALC back to IDLE
			high_valid <= (st_hs == sw_ctrl_pkg::CALC) && !en_out;
		end
	end

endmodule

/* design/sw_gap_prep.sv */
// stage 1 with substitution pick, diagonal registers and left gap candidates
`timescale 1ns/10ps

module sw_gap_prep
(
	input  logic clk,
	input  logic rst,
	input  logic s1_load, // capture this cycle
	input  logic s1_first, // first base of a run
	input  sw_score_pkg::base_t base_in, // target base
	input  sw_score_pkg::base_t query, // base held by this cell
	input  sw_score_pkg::score_t m_in, // left neighbour M
	input  sw_score_pkg::score_t i_in, // left neighbour I
	input  sw_score_pkg::score_t match, // two's complement offset
	input  sw_score_pkg::score_t mismatch,
	input  sw_score_pkg::score_t gap_open,
	input  sw_score_pkg::score_t gap_extend,
	output sw_score_pkg::base_t base_r, // base to stage 2
	output sw_score_pkg::score_t lut_r, // substitution score
	output sw_score_pkg::score_t diag_r, // diagonal max
	output sw_score_pkg::score_t left_open_r, // gap opened from left M
	output sw_score_pkg::score_t left_ext_r // gap extended from left I
);

	sw_score_pkg::score_t m_diag; // previous item's m_in
	sw_score_pkg::score_t i_diag; // previous item's i_in
	sw_score_pkg::score_t lut; // match or mismatch
	sw_score_pkg::score_t diag_max; // diagonal candidate
	sw_score_pkg::score_t left_open; // m_in + open + extend
	sw_score_pkg::score_t left_ext; // i_in + extend

	// ====================
	// combinational picks
	// ====================

	assign lut = (base_in == query) ? match : mismatch;
	assign diag_max = s1_first ? sw_score_pkg::ZERO : sw_score_pkg::max2(m_diag, i_diag);
	assign left_open = m_in + gap_open + gap_extend; // wraps at width
	assign left_ext = i_in + gap_extend;

	// left scores become the diagonal of the next base
	always_ff @(posedge clk)
	begin
		if (s1_load)
		begin
			m_diag <= m_in;
			i_diag <= i_in;
		end
	end

	// ====================
	// stage 1 registers
	// ====================

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			base_r <= sw_score_pkg::A;
			lut_r <= sw_score_pkg::ZERO;
			diag_r <= sw_score_pkg::ZERO;
			left_open_r <= sw_score_pkg::ZERO;
			left_ext_r <= sw_score_pkg::ZERO;
		end
		else if (s1_load)
		begin
			base_r <= base_in;
			lut_r <= lut;
			diag_r <= diag_max;
			left_open_r <= left_open;
			left_ext_r <= left_ext;
		end
		else
		begin
			base_r <= sw_score_pkg::A; // idle clears
			lut_r <= sw_score_pkg::ZERO;
			diag_r <= sw_score_pkg::ZERO;
			left_open_r <= sw_score_pkg::ZERO;
			left_ext_r <= sw_score_pkg::ZERO;
		end
	end

endmodule

/* design/sw_cell_score.sv */
// stage 2 with clamped M, four-way gap maximum I and output registers
`timescale 1ns/10ps

module sw_cell_score
(
	input  logic clk,
	input  logic rst,
	input  logic s2_load, // capture this cycle
	input  logic s2_first, // first base of a run
	input  sw_score_pkg::base_t base_r,
	input  sw_score_pkg::score_t lut_r,
	input  sw_score_pkg::score_t diag_r,
	input  sw_score_pkg::score_t left_open_r,
	input  sw_score_pkg::score_t left_ext_r,
	input  sw_score_pkg::score_t gap_open,
	input  sw_score_pkg::score_t gap_extend,
	output sw_score_pkg::base_t base_out, // base to right neighbour
	output sw_score_pkg::score_t m_out, // M to right neighbour
	output sw_score_pkg::score_t i_out // I to right neighbour
);

	sw_score_pkg::score_t m_sum; // lut + diag before clamp
	sw_score_pkg::score_t m_new; // clamped M
	sw_score_pkg::score_t up_m; // own previous M
	sw_score_pkg::score_t up_i; // own previous I
	sw_score_pkg::score_t up_open; // gap opened from up M
	sw_score_pkg::score_t up_ext; // gap extended from up I
	sw_score_pkg::score_t i_new; // largest gap candidate

	// ====================
	// cell score
	// ====================

	assign m_sum = lut_r + diag_r;
	assign m_new = m_sum[$bits(m_sum)-1] ? m_sum : sw_score_pkg::ZERO; // below biased zero clamps

	// up terms come from the output regs, previous base of this run
	assign up_m = s2_first ? sw_score_pkg::ZERO : m_out;
	assign up_i = s2_first ? sw_score_pkg::ZERO : i_out;
	assign up_open = up_m + gap_open + gap_extend;
	assign up_ext = up_i + gap_extend;
	assign i_new = sw_score_pkg::max2(sw_score_pkg::max2(left_open_r, left_ext_r),
		sw_score_pkg::max2(up_open, up_ext));

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			base_out <= sw_score_pkg::A;
			m_out <= sw_score_pkg::ZERO;
			i_out <= sw_score_pkg::ZERO;
		end
		else if (s2_load)
		begin
			base_out <= base_r;
			m_out <= m_new;
			i_out <= i_new;
		end
		else
		begin
			base_out <= sw_score_pkg::A; // idle outputs
			m_out <= sw_score_pkg::ZERO;
			i_out <= sw_score_pkg::ZERO;
		end
	end

endmodule

/* design/sw_high_score.sv */
// stage 3 with the running high score register
`timescale 1ns/10ps

module sw_high_score
(
	input  logic clk,
	input  logic rst,
	input  logic en_out, // stage 2 result valid
	input  logic hs_first, // first result of a run
	input  sw_score_pkg::score_t m_out,
	input  sw_score_pkg::score_t i_out,
	input  sw_score_pkg::score_t high_in, // left neighbour high score
	output sw_score_pkg::score_t high_out // running high, held when idle
);

	sw_score_pkg::score_t high_prev; // own high, dropped on first item
	sw_score_pkg::score_t cell_max; // max of M and I
	sw_score_pkg::score_t high_new; // next running high

	// ====================
	// high score
	// ====================

	assign high_prev = hs_first ? sw_score_pkg::ZERO : high_out; // restart per run
	assign cell_max = sw_score_pkg::max2(m_out, i_out);
	assign high_new = sw_score_pkg::max2(sw_score_pkg::max2(high_in, high_prev), cell_max);

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			high_out <= sw_score_pkg::ZERO;
		end
		else if (en_out)
		begin
			high_out <= high_new; // high_in only sampled here
		end
	end

endmodule

/* design/sw_pe.sv */
// Smith-Waterman processing element top with controller and three stages
`timescale 1ns/10ps

module sw_pe
(
	input  logic clk,
	input  logic rst,
	input  logic en_in, // run enable
	input  sw_score_pkg::base_t base_in, // streamed target base
	input  sw_score_pkg::base_t query, // base held by this cell
	input  sw_score_pkg::score_t m_in,
	input  sw_score_pkg::score_t i_in,
	input  sw_score_pkg::score_t high_in,
	input  sw_score_pkg::score_t match,
	input  sw_score_pkg::score_t mismatch,
	input  sw_score_pkg::score_t gap_open,
	input  sw_score_pkg::score_t gap_extend,
	output sw_score_pkg::base_t base_out,
	output sw_score_pkg::score_t m_out,
	output sw_score_pkg::score_t i_out,
	output sw_score_pkg::score_t high_out,
	output logic en_out,
	output logic high_valid
);

	logic s1_load;
	logic s1_first;
	logic s2_load;
	logic s2_first;
	logic hs_first;
	sw_score_pkg::base_t base_r; // stage 1 to stage 2
	sw_score_pkg::score_t lut_r;
	sw_score_pkg::score_t diag_r;
	sw_score_pkg::score_t left_open_r;
	sw_score_pkg::score_t left_ext_r;

	// ====================
	// control
	// ====================

	sw_pe_ctrl sw_pe_ctrl_inst
	(
		.clk(clk),
		.rst(rst),
		.en_in(en_in),
		.s1_load(s1_load),
		.s1_first(s1_first),
		.s2_load(s2_load),
		.s2_first(s2_first),
		.en_out(en_out),
		.hs_first(hs_first),
		.high_valid(high_valid)
	);

	// ====================
	// datapath stages
	// ====================

	sw_gap_prep sw_gap_prep_inst
	(
		.clk(clk),
		.rst(rst),
		.s1_load(s1_load),
		.s1_first(s1_first),
		.base_in(base_in),
		.query(query),
		.m_in(m_in),
		.i_in(i_in),
		.match(match),
		.mismatch(mismatch),
		.gap_open(gap_open),
		.gap_extend(gap_extend),
		.base_r(base_r),
		.lut_r(lut_r),
		.diag_r(diag_r),
		.left_open_r(left_open_r),
		.left_ext_r(left_ext_r)
	);

	sw_cell_score sw_cell_score_inst
	(
		.clk(clk),
		.rst(rst),
		.s2_load(s2_load),
		.s2_first(s2_first),
		.base_r(base_r),
		.lut_r(lut_r),
		.diag_r(diag_r),
		.left_open_r(left_open_r),
		.left_ext_r(left_ext_r),
		.gap_open(gap_open),
		.gap_extend(gap_extend),
		.base_out(base_out),
		.m_out(m_out),
		.i_out(i_out)
	);

	sw_high_score sw_high_score_inst
	(
		.clk(clk),
		.rst(rst),
		.en_out(en_out),
		.hs_first(hs_first),
		.m_out(m_out),
		.i_out(i_out),
		.high_in(high_in),
		.high_out(high_out)
	);

endmodule

/* tb/sw_pe_props.sv */
// bound assertions on the enable delay, valid pulse width and the M floor
`timescale 1ns/10ps

module sw_pe_props
(
	input logic clk,
	input logic rst,
	input logic en_in,
	input logic en_out,
	input logic high_valid,
	input sw_score_pkg::score_t m_out
);

	int fail_cnt = 0; // read back by the testbench

	// ====================
	// properties
	// ====================

	property en_two_cycles;
		@(posedge clk) disable iff (!rst) en_out == $past(en_in, 2); // two stage latency
	endproperty

	property valid_one_cycle;
		@(posedge clk) disable iff (!rst) high_valid |=> !high_valid;
	endproperty

	// idle M rests on the biased zero
	property m_floor;
		@(posedge clk) disable iff (!rst) !en_out |-> (m_out == sw_score_pkg::ZERO);
	endproperty

	assert property (en_two_cycles)
	else
	begin
		$error("en_out is not en_in delayed by two cycles");
		fail_cnt++;
	end

	assert property (valid_one_cycle)
	else
	begin
		$error("high_valid stayed high longer than one cycle");
		fail_cnt++;
	end

	assert property (m_floor)
	else
	begin
		$error("m_out off the biased zero while en_out is low");
		fail_cnt++;
	end

endmodule

bind sw_pe sw_pe_props sw_pe_props_inst
(
	.clk(clk),
	.rst(rst),
	.en_in(en_in),
	.en_out(en_out),
	.high_valid(high_valid),
	.m_out(m_out)
);

/* tb/sw_pe_tb.sv */
// testbench for the Smith-Waterman cell with seeded stimulus, reference model and checks
`timescale 1ns/10ps

module sw_pe_tb;

	logic clk;
	logic rst;
	logic en_in;
	sw_score_pkg::base_t base_in;
	sw_score_pkg::base_t query;
	sw_score_pkg::score_t m_in;
	sw_score_pkg::score_t i_in;
	sw_score_pkg::score_t high_in;
	sw_score_pkg::score_t match;
	sw_score_pkg::score_t mismatch;
	sw_score_pkg::score_t gap_open;
	sw_score_pkg::score_t gap_extend;
	sw_score_pkg::base_t base_out;
	sw_score_pkg::score_t m_out;
	sw_score_pkg::score_t i_out;
	sw_score_pkg::score_t high_out;
	logic en_out;
	logic high_valid;

	// ====================
	// model state
	// ====================

	sw_score_pkg::score_t q_m[$]; // expected m_out per cycle, 2 deep
	sw_score_pkg::score_t q_i[$];
	sw_score_pkg::base_t q_b[$];
	logic q_en[$];
	logic q_first[$]; // item opens a run
	sw_score_pkg::score_t model_high; // expected high_out
	sw_score_pkg::score_t diag_m; // left M of previous item
	sw_score_pkg::score_t diag_i;
	sw_score_pkg::score_t own_m; // cell M of previous item
	sw_score_pkg::score_t own_i;
	logic drv_en_prev; // en_in one cycle back
	logic out_en_prev; // expected en_out one cycle back
	logic exp_valid; // expected high_valid
	int test_errs;
	int total_errs;
	int tests_run;
	int tests_bad;

	sw_pe sw_pe_inst
	(
		.clk(clk),
		.rst(rst),
		.en_in(en_in),
		.base_in(base_in),
		.query(query),
		.m_in(m_in),
		.i_in(i_in),
		.high_in(high_in),
		.match(match),
		.mismatch(mismatch),
		.gap_open(gap_open),
		.gap_extend(gap_extend),
		.base_out(base_out),
		.m_out(m_out),
		.i_out(i_out),
		.high_out(high_out),
		.en_out(en_out),
		.high_valid(high_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// unsigned compare on biased words
	function automatic sw_score_pkg::score_t larger(input sw_score_pkg::score_t a,
		input sw_score_pkg::score_t b);
		if (a > b)
			return a;
		return b;
	endfunction

	function automatic sw_score_pkg::score_t rand_score();
		return sw_score_pkg::ZERO + sw_score_pkg::score_t'($urandom_range(300)); // ZERO..ZERO+300
	endfunction

	function automatic sw_score_pkg::score_t offset(input int k);
		return sw_score_pkg::score_t'(k); // two's complement at score width
	endfunction

	task automatic check_score(input string name, input sw_score_pkg::score_t got,
		input sw_score_pkg::score_t exp);
		assert (got === exp)
		else
		begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			test_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		assert (got === exp)
		else
		begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			test_errs++;
		end
	endtask

	task automatic push_idle();
		q_m.push_back(sw_score_pkg::ZERO);
		q_i.push_back(sw_score_pkg::ZERO);
		q_b.push_back(sw_score_pkg::A);
		q_en.push_back(1'b0);
		q_first.push_back(1'b0);
	endtask

	// ====================
	// one cycle: check outputs, model the new item, drive it
	// ====================

	task automatic step(input logic en, input sw_score_pkg::base_t b,
		input sw_score_pkg::score_t m, input sw_score_pkg::score_t i,
		input sw_score_pkg::score_t hi);
		sw_score_pkg::score_t em;
		sw_score_pkg::score_t ei;
		sw_score_pkg::base_t eb;
		logic een;
		logic efirst;
		logic first;
		sw_score_pkg::score_t lut;
		sw_score_pkg::score_t diag;
		sw_score_pkg::score_t m_sum;
		sw_score_pkg::score_t up_m;
		sw_score_pkg::score_t up_i;
		em = q_m.pop_front(); // item driven two steps back
		ei = q_i.pop_front();
		eb = q_b.pop_front();
		een = q_en.pop_front();
		efirst = q_first.pop_front();
		check_score("m_out", m_out, em);
		check_score("i_out", i_out, ei);
		check_score("base_out", sw_score_pkg::score_t'(base_out), sw_score_pkg::score_t'(eb));
		check_flag("en_out", en_out, een);
		check_flag("high_valid", high_valid, exp_valid);
		check_score("high_out", high_out, model_high);
		exp_valid = out_en_prev && !een; // pulse after the run drains
		out_en_prev = een;
		// high stage takes the high_in driven now at the next edge
		if (een)
			model_high = larger(larger(hi, efirst ? sw_score_pkg::ZERO : model_high),
				larger(em, ei));
		if (en)
		begin
			first = !drv_en_prev;
			lut = (b == query) ? match : mismatch;
			diag = first ? sw_score_pkg::ZERO : larger(diag_m, diag_i);
			m_sum = lut + diag;
			up_m = first ? sw_score_pkg::ZERO : own_m; // up terms restart per run
			up_i = first ? sw_score_pkg::ZERO : own_i;
			own_i = larger(larger(m + gap_open + gap_extend, i + gap_extend),
				larger(up_m + gap_open + gap_extend, up_i + gap_extend));
			own_m = m_sum[$bits(m_sum)-1] ? m_sum : sw_score_pkg::ZERO; // floor at biased zero
			q_m.push_back(own_m);
			q_i.push_back(own_i);
			q_b.push_back(b);
			q_en.push_back(1'b1);
			q_first.push_back(first);
			diag_m = m;
			diag_i = i;
		end
		else
		begin
			push_idle();
		end
		drv_en_prev = en;
		en_in = en;
		base_in = b;
		m_in = m;
		i_in = i;
		high_in = hi;
		@(posedge clk);
		#2; // drive point after the edge
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) step(1'b0, sw_score_pkg::A, rand_score(), rand_score(), rand_score());
	endtask

	task automatic random_run(input int n, input logic no_match);
		sw_score_pkg::base_t b;
		for (int k = 0; k < n; k++)
		begin
			if (no_match)
				b = sw_score_pkg::base_t'(query ^ 2'($urandom_range(3, 1))); // never the query
			else
				b = sw_score_pkg::base_t'(2'($urandom_range(3)));
			step(1'b1, b, rand_score(), rand_score(), rand_score());
			if (no_match)
				check_score("m_out", m_out, sw_score_pkg::ZERO);
		end
	endtask

	// only called with the pipe drained
	task automatic set_params(input int mm);
		query = sw_score_pkg::base_t'(2'($urandom_range(3)));
		match = offset($urandom_range(5, 2));
		mismatch = offset(mm);
		gap_open = offset(-int'($urandom_range(4, 2)));
		gap_extend = offset(-int'($urandom_range(2, 1)));
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		while (!high_valid && n < 10) // bounded wait
		begin
			idle_cycles(1);
			n++;
		end
		assert (high_valid)
		else
		begin
			$display("high_valid did not rise within 10 cycles after the run");
			test_errs++;
		end
		check_score("high_out", high_out, model_high); // final run high
	endtask

	task automatic end_test(input string name);
		tests_run++;
		total_errs += test_errs;
		if (test_errs != 0)
			tests_bad++;
		$display("test %0d %s: %s, %0d errors", tests_run, name,
			(test_errs == 0) ? "ok" : "FAIL", test_errs);
		test_errs = 0;
	endtask

	// ====================
	// test sequence
	// ====================

	initial
	begin
		void'($urandom(75092));
		rst = 1'b0;
		en_in = 1'b0;
		base_in = sw_score_pkg::A;
		query = sw_score_pkg::A;
		m_in = sw_score_pkg::ZERO;
		i_in = sw_score_pkg::ZERO;
		high_in = sw_score_pkg::ZERO;
		match = offset(2);
		mismatch = offset(-1);
		gap_open = offset(-3);
		gap_extend = offset(-1);
		test_errs = 0;
		total_errs = 0;
		tests_run = 0;
		tests_bad = 0;
		model_high = sw_score_pkg::ZERO;
		diag_m = sw_score_pkg::ZERO;
		diag_i = sw_score_pkg::ZERO;
		own_m = sw_score_pkg::ZERO;
		own_i = sw_score_pkg::ZERO;
		drv_en_prev = 1'b0;
		out_en_prev = 1'b0;
		exp_valid = 1'b0;
		repeat (2) push_idle(); // pipe is empty after reset
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b1;

		check_flag("en_out", en_out, 1'b0);
		check_flag("high_valid", high_valid, 1'b0);
		check_score("m_out", m_out, sw_score_pkg::ZERO);
		check_score("i_out", i_out, sw_score_pkg::ZERO);
		check_score("base_out", sw_score_pkg::score_t'(base_out), sw_score_pkg::score_t'(0));
		check_score("high_out", high_out, sw_score_pkg::ZERO);
		end_test("reset state");

		set_params(-int'($urandom_range(3, 1)));
		random_run(20, 1'b0);
		idle_cycles(5);
		end_test("random run scores");

		set_params(-400); // deep mismatch forces the M floor
		random_run(20, 1'b1);
		idle_cycles(5);
		end_test("mismatch floor");

		set_params(-int'($urandom_range(3, 1)));
		random_run(20, 1'b0);
		wait_valid();
		idle_cycles(3);
		end_test("high score and valid");

		random_run(6, 1'b0);
		idle_cycles(1); // single idle gap
		random_run(8, 1'b0);
		wait_valid();
		idle_cycles(3);
		end_test("back to back runs");

		if (sw_pe_inst.sw_pe_props_inst.fail_cnt != 0)
		begin
			$display("bound assertions fired %0d times", sw_pe_inst.sw_pe_props_inst.fail_cnt);
			total_errs += sw_pe_inst.sw_pe_props_inst.fail_cnt;
		end
		$display("tests %0d, failing %0d, errors %0d", tests_run, tests_bad, total_errs);
		if (total_errs == 0)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+design
design/sw_score_pkg.sv
design/sw_ctrl_pkg.sv
design/sw_pe_ctrl.sv
design/sw_gap_prep.sv
design/sw_cell_score.sv
design/sw_high_score.sv
design/sw_pe.sv
tb/sw_pe_props.sv
tb/sw_pe_tb.sv

/* Makefile */
# Verilator build and run for the Smith-Waterman cell testbench

VERILATOR ?= verilator
TOP ?= sw_pe_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
SIM_ARGS ?= +verilator+error+limit+1000

.PHONY: sim clean

# pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --assert --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
